/* layer_norm_lite.f */
+incdir+source
source/ln_pkg.sv
source/ln_adder_tree.sv
source/ln_mean_unit.sv
source/ln_cfg_regs.sv
source/ln_lane.sv
source/ln_out_collect.sv
source/layer_norm_top.sv
testbench/tb_layer_norm.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f layer_norm_lite.f \
        --top-module tb_layer_norm -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -Fqx "=== PASS ===" \
    || exit 1

/* testbench/tb_layer_norm.sv */
`timescale 1ns/1ps
`include "ln_defs.svh"

module tb_layer_norm;

    import ln_pkg::*;

    localparam int NUM_ELEM = `LN_LANES * `LN_BEATS;
    localparam int NUM_ROWS = 10;
    localparam int WAIT_MAX = 200;
    localparam int SAT_HI   = 127;
    localparam int SAT_LO   = -128;

    typedef struct packed {
        ln_coef_vec_t                         coef;
        logic [`LN_SHIFT_W-1:0]               shift;
        logic                                 use_rand;
        logic [1:0]                           gap;
        logic [NUM_ELEM-1:0][`LN_DATA_W-1:0] elem;
        logic [NUM_ELEM-1:0][`LN_DATA_W-1:0] exp_out;
    } test_row_t;

    logic         clk;
    logic         rstn;
    logic         cfg_wr;
    logic         cfg_addr;
    ln_cfg_word_u cfg_data;
    ln_beat_t     in_beat;
    ln_beat_t     out_beat;
    logic         out_last;

    test_row_t   table_rows [NUM_ROWS];
    string       row_name [NUM_ROWS];
    logic [15:0] lfsr_state;
    int          pass_cnt;
    int          fail_cnt;
    int          test_errs;

    layer_norm_top i_dut (
        .clk      (clk),
        .rstn     (rstn),
        .cfg_wr   (cfg_wr),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .in_beat  (in_beat),
        .out_beat (out_beat),
        .out_last (out_last)
    );

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // expected outputs from the floored mean, then scale, shift, bias and clamp
    function automatic test_row_t model_row(input test_row_t r);
        test_row_t res;
        int        sum;
        int        mean;
        int        lane;
        int        v;
        res = r;
        sum = 0;
        for (int k = 0; k < NUM_ELEM; k++) begin
            sum += int'($signed(r.elem[k]));
        end
        mean = sum >>> `LN_MEAN_SHIFT;
        for (int k = 0; k < NUM_ELEM; k++) begin
            lane = k % `LN_LANES;
            v = (int'($signed(r.elem[k])) - mean) * int'($signed(r.coef[lane].gamma));
            v = (v >>> r.shift) + int'($signed(r.coef[lane].beta));
            if (v > SAT_HI) begin
                v = SAT_HI;
            end else if (v < SAT_LO) begin
                v = SAT_LO;
            end
            res.exp_out[k] = v[`LN_DATA_W-1:0];
        end
        return res;
    endfunction

    task automatic build_table();
        logic [31:0] bits;
        for (int r = 0; r < NUM_ROWS; r++) begin
            table_rows[r] = '0;
            table_rows[r].use_rand = (r >= 5);
            row_name[r] = $sformatf("random vector %0d", r - 4);
            for (int l = 0; l < `LN_LANES; l++) begin
                table_rows[r].coef[l].gamma = 8'sd1;
            end
        end
        row_name[0] = "constant vector";
        row_name[1] = "ramp vector";
        row_name[2] = "negative sum";
        row_name[3] = "saturation";
        row_name[4] = "saturation, larger shift";
        table_rows[0].shift = 4'd2;
        table_rows[2].gap   = 2'd1;
        table_rows[4].shift = 4'd8;
        for (int l = 0; l < `LN_LANES; l++) begin
            table_rows[0].coef[l].gamma = 8'(l * 17 - 60);
            table_rows[0].coef[l].beta  = 8'(l * 20 - 70);
            table_rows[3].coef[l].gamma = 8'((l % 2 == 0) ? 100 : -90);
            table_rows[4].coef[l].gamma = 8'((l % 2 == 0) ? 100 : -90);
            table_rows[4].coef[l].beta  = 8'sd3;
        end
        for (int k = 0; k < NUM_ELEM; k++) begin
            table_rows[0].elem[k] = 8'd37;
            table_rows[1].elem[k] = 8'(k);
            table_rows[2].elem[k] = 8'((k % 2 == 0) ? -5 : 4);
            // lane parity flips every beat so both rails get hit
            table_rows[3].elem[k] = 8'(((k + k / `LN_LANES) % 2 == 0) ? 127 : -128);
            table_rows[4].elem[k] = table_rows[3].elem[k];
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (table_rows[r].use_rand) begin
                for (int l = 0; l < `LN_LANES; l++) begin
                    take_bits(8, bits);
                    table_rows[r].coef[l].gamma = bits[7:0];
                    take_bits(8, bits);
                    table_rows[r].coef[l].beta = bits[7:0];
                end
                take_bits(`LN_SHIFT_W, bits);
                table_rows[r].shift = bits[`LN_SHIFT_W-1:0];
                take_bits(2, bits);
                table_rows[r].gap = bits[1:0];
                for (int k = 0; k < NUM_ELEM; k++) begin
                    take_bits(8, bits);
                    table_rows[r].elem[k] = bits[7:0];
                end
            end
            table_rows[r] = model_row(table_rows[r]);
        end
    endtask

    task automatic write_config(input test_row_t r);
        @(negedge clk);
        cfg_wr        = 1'b1;
        cfg_addr      = 1'(`LN_ADDR_COEF);
        cfg_data.coef = r.coef;
        @(negedge clk);
        cfg_addr            = 1'(`LN_ADDR_CTRL);
        cfg_data            = '0;
        cfg_data.ctrl.shift = r.shift;
        @(negedge clk);
        cfg_wr = 1'b0;
    endtask

    task automatic send_vector(input test_row_t r);
        for (int b = 0; b < `LN_BEATS; b++) begin
            @(negedge clk);
            in_beat.vld = 1'b1;
            for (int l = 0; l < `LN_LANES; l++) begin
                in_beat.data[l] = r.elem[b*`LN_LANES + l];
            end
            for (int g = 0; g < int'(r.gap); g++) begin
                @(negedge clk);
                in_beat.vld = 1'b0;
            end
        end
        @(negedge clk);
        in_beat.vld = 1'b0;
    endtask

    task automatic check_idle(output int errs);
        errs = 0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            assert (!out_beat.vld) else begin
                $display("Mismatch out_beat.vld: expected 0x0, got 0x%h", out_beat.vld);
                errs++;
            end
            assert (!out_last) else begin
                $display("Mismatch out_last: expected 0x0, got 0x%h", out_last);
                errs++;
            end
        end
    endtask

    task automatic check_vector(input test_row_t r, output int errs);
        int                    waited;
        logic                  lost;
        logic [`LN_DATA_W-1:0] exp_val;
        logic [`LN_DATA_W-1:0] got_val;
        errs = 0;
        lost = 1'b0;
        for (int b = 0; b < `LN_BEATS && !lost; b++) begin
            @(negedge clk);
            waited = 1;
            while (!out_beat.vld && waited < WAIT_MAX) begin
                @(negedge clk);
                waited++;
            end
            assert (out_beat.vld) else begin
                $display("output beat %0d never arrived within %0d cycles", b, WAIT_MAX);
                errs++;
            end
            lost = !out_beat.vld;
            if (!lost) begin
                for (int l = 0; l < `LN_LANES; l++) begin
                    exp_val = r.exp_out[b*`LN_LANES + l];
                    got_val = out_beat.data[l];
                    assert (got_val == exp_val) else begin
                        $display("Mismatch out_beat.data[%0d] beat %0d: expected 0x%h, got 0x%h",
                                 l, b, exp_val, got_val);
                        errs++;
                    end
                end
                if (b == `LN_BEATS - 1) begin
                    assert (out_last) else begin
                        $display("out_last missing on the final beat of the vector");
                        errs++;
                    end
                end else begin
                    assert (!out_last) else begin
                        $display("Mismatch out_last beat %0d: expected 0x0, got 0x%h",
                                 b, out_last);
                        errs++;
                    end
                end
            end
        end
        // nothing may follow the last beat
        for (int i = 0; i < 4 && !lost; i++) begin
            @(negedge clk);
            assert (!out_beat.vld) else begin
                $display("Mismatch out_beat.vld after last beat: expected 0x0, got 0x%h",
                         out_beat.vld);
                errs++;
            end
            assert (!out_last) else begin
                $display("Mismatch out_last after last beat: expected 0x0, got 0x%h",
                         out_last);
                errs++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        cfg_wr     = 1'b0;
        cfg_addr   = 1'b0;
        cfg_data   = '0;
        in_beat    = '0;
        lfsr_state = 16'd30;
        pass_cnt   = 0;
        fail_cnt   = 0;
        build_table();
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        check_idle(test_errs);
        report_test("idle after reset", test_errs);
        for (int r = 0; r < NUM_ROWS; r++) begin
            write_config(table_rows[r]);
            send_vector(table_rows[r]);
            check_vector(table_rows[r], test_errs);
            report_test(row_name[r], test_errs);
        end
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* source/layer_norm_top.sv */
`timescale 1ns/1ps
`include "ln_defs.svh"

module layer_norm_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 cfg_wr,
    input  logic                 cfg_addr,
    input  ln_pkg::ln_cfg_word_u cfg_data,
    input  ln_pkg::ln_beat_t     in_beat,
    output ln_pkg::ln_beat_t     out_beat,
    output logic                 out_last
);

    import ln_pkg::*;

    logic signed [`LN_DATA_W-1:0] mean;
    ln_lane_in_t                  lane_in [`LN_LANES];
    ln_lane_out_t                 lane_out [`LN_LANES];
    ln_coef_vec_t                 coef;
    logic [`LN_SHIFT_W-1:0]       shift;

    ln_mean_unit i_mean (
        .clk     (clk),
        .rstn    (rstn),
        .in_beat (in_beat),
        .mean    (mean),
        .lane_in (lane_in)
    );

    ln_cfg_regs i_cfg (
        .clk      (clk),
        .rstn     (rstn),
        .cfg_wr   (cfg_wr),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .coef     (coef),
        .shift    (shift)
    );

    // one pipeline per lane, shared mean and shift
    generate
        for (genvar g = 0; g < `LN_LANES; g++) begin : g_lane
            ln_lane i_lane (
                .clk      (clk),
                .rstn     (rstn),
                .lane_in  (lane_in[g]),
                .mean     (mean),
                .coef     (coef[g]),
                .shift    (shift),
                .lane_out (lane_out[g])
            );
        end
    endgenerate

    ln_out_collect i_collect (
        .clk      (clk),
        .rstn     (rstn),
        .lane_out (lane_out),
        .out_beat (out_beat),
        .out_last (out_last)
    );

endmodule

/* source/ln_out_collect.sv */
`timescale 1ns/1ps
`include "ln_defs.svh"

module ln_out_collect (
    input  logic                 clk,
    input  logic                 rstn,
    input  ln_pkg::ln_lane_out_t lane_out [`LN_LANES],
    output ln_pkg::ln_beat_t     out_beat,
    output logic                 out_last
);

    localparam int               CNT_W    = $clog2(`LN_BEATS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`LN_BEATS - 1);

    logic [CNT_W-1:0]                     beat_cnt;
    logic                                 beat_vld;
    logic [`LN_LANES-1:0][`LN_DATA_W-1:0] beat_data;

    // lanes run in lockstep, lane 0 speaks for all
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_vld <= 1'b0;
            out_last <= 1'b0;
            beat_cnt <= '0;
        end else begin
            beat_vld <= lane_out[0].vld;
            out_last <= lane_out[0].vld && (beat_cnt == CNT_LAST);
            if (lane_out[0].vld) begin
                beat_cnt <= (beat_cnt == CNT_LAST) ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lane_out[0].vld) begin
            for (int i = 0; i < `LN_LANES; i++) begin
                beat_data[i] <= lane_out[i].data;
            end
        end
    end

    always_comb begin
        out_beat.vld  = beat_vld;
        out_beat.data = beat_data;
    end

endmodule

/* source/ln_lane.sv */
`timescale 1ns/1ps
`include "ln_defs.svh"

module ln_lane (
    input  logic                         clk,
    input  logic                         rstn,
    input  ln_pkg::ln_lane_in_t          lane_in,
    input  logic signed [`LN_DATA_W-1:0] mean,
    input  ln_pkg::ln_coef_t             coef,
    input  logic [`LN_SHIFT_W-1:0]       shift,
    output ln_pkg::ln_lane_out_t         lane_out
);

    localparam int PROD_W = 2 * `LN_DATA_W + 1;
    localparam int BIAS_W = PROD_W + 1;
    localparam logic signed [BIAS_W-1:0] SAT_MAX = BIAS_W'((1 << (`LN_DATA_W - 1)) - 1);
    localparam logic signed [BIAS_W-1:0] SAT_MIN = BIAS_W'(-(1 << (`LN_DATA_W - 1)));

    logic signed [`LN_DATA_W:0]   centered;
    logic signed [PROD_W-1:0]     prod;
    logic signed [PROD_W-1:0]     prod_q;
    logic                         prod_vld;
    logic signed [PROD_W-1:0]     scaled;
    logic signed [BIAS_W-1:0]     biased;
    logic signed [`LN_DATA_W-1:0] sat;
    logic signed [`LN_DATA_W-1:0] res_q;
    logic                         res_vld;

    // stage 1: center and scale
    assign centered = $signed(lane_in.data) - mean;
    assign prod     = centered * $signed(coef.gamma);

    // stage 2: shift, bias, clamp
    assign scaled = prod_q >>> shift;
    assign biased = scaled + $signed(coef.beta);

    always_comb begin
        if (biased > SAT_MAX) begin
            sat = SAT_MAX[`LN_DATA_W-1:0];
        end else if (biased < SAT_MIN) begin
            sat = SAT_MIN[`LN_DATA_W-1:0];
        end else begin
            sat = biased[`LN_DATA_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prod_vld <= 1'b0;
            res_vld  <= 1'b0;
        end else begin
            prod_vld <= lane_in.vld;
            res_vld  <= prod_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (lane_in.vld) begin
            prod_q <= prod;
        end
        if (prod_vld) begin
            res_q <= sat;
        end
    end

    always_comb begin
        lane_out.vld  = res_vld;
        lane_out.data = res_q;
    end

endmodule

/* source/ln_cfg_regs.sv */
`timescale 1ns/1ps
`include "ln_defs.svh"

module ln_cfg_regs (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   cfg_wr,
    input  logic                   cfg_addr,
    input  ln_pkg::ln_cfg_word_u   cfg_data,
    output ln_pkg::ln_coef_vec_t   coef,
    output logic [`LN_SHIFT_W-1:0] shift
);

    import ln_pkg::*;

    // identity scale, no offset
    localparam ln_coef_t COEF_RST = '{gamma: `LN_DATA_W'(1), beta: `LN_DATA_W'(0)};

    logic coef_sel;
    logic ctrl_sel;

    assign coef_sel = cfg_wr && (cfg_addr == 1'(`LN_ADDR_COEF));
    assign ctrl_sel = cfg_wr && (cfg_addr == 1'(`LN_ADDR_CTRL));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `LN_LANES; i++) begin
                coef[i] <= COEF_RST;
            end
            shift <= '0;
        end else begin
            if (coef_sel) begin
                coef <= cfg_data.coef;
            end
            // pad bits of the control view are ignored
            if (ctrl_sel) begin
                shift <= cfg_data.ctrl.shift;
            end
        end
    end

endmodule

/* source/ln_mean_unit.sv */
`timescale 1ns/1ps
`include "ln_defs.svh"

module ln_mean_unit (
    input  logic                         clk,
    input  logic                         rstn,
    input  ln_pkg::ln_beat_t             in_beat,
    output logic signed [`LN_DATA_W-1:0] mean,
    output ln_pkg::ln_lane_in_t          lane_in [`LN_LANES]
);

    localparam int              PTR_W      = $clog2(`LN_BEATS);
    localparam logic [PTR_W-1:0] PTR_LAST   = PTR_W'(`LN_BEATS - 1);
    localparam logic [PTR_W:0]   BEAT_TOTAL = (PTR_W+1)'(`LN_BEATS);

    logic signed [`LN_SUM_W-1:0]           tree_sum;
    logic                                  tree_vld;
    logic signed [`LN_SUM_W-1:0]           acc;
    logic signed [`LN_SUM_W-1:0]           acc_avg;
    logic [PTR_W:0]                        sum_cnt;
    logic                                  mean_load;
    logic [PTR_W-1:0]                      wr_ptr;
    logic [PTR_W-1:0]                      rd_ptr;
    logic                                  replay_on;
    logic                                  replay_vld;
    logic [`LN_LANES-1:0][`LN_DATA_W-1:0]  beat_buf [`LN_BEATS];
    logic [`LN_LANES-1:0][`LN_DATA_W-1:0]  replay_data;

    ln_adder_tree i_tree (
        .clk     (clk),
        .rstn    (rstn),
        .in_data (in_beat.data),
        .in_vld  (in_beat.vld),
        .sum     (tree_sum),
        .sum_vld (tree_vld)
    );

    // all beat sums in, mean goes out next edge
    assign mean_load = (sum_cnt == BEAT_TOTAL);
    assign acc_avg   = acc >>> `LN_MEAN_SHIFT;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc     <= '0;
            sum_cnt <= '0;
        end else if (mean_load) begin
            acc     <= '0;
            sum_cnt <= '0;
        end else if (tree_vld) begin
            acc     <= acc + tree_sum;
            sum_cnt <= sum_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mean_load) begin
            mean <= acc_avg[`LN_DATA_W-1:0];
        end
    end

    // beat buffer, filled in arrival order
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (in_beat.vld) begin
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_beat.vld) begin
            beat_buf[wr_ptr] <= in_beat.data;
        end
    end

    // replay one beat per cycle once the mean is known
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            replay_on  <= 1'b0;
            rd_ptr     <= '0;
            replay_vld <= 1'b0;
        end else begin
            replay_vld <= replay_on;
            if (mean_load) begin
                replay_on <= 1'b1;
                rd_ptr    <= '0;
            end else if (replay_on) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
                if (rd_ptr == PTR_LAST) begin
                    replay_on <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        replay_data <= beat_buf[rd_ptr];
    end

    always_comb begin
        for (int i = 0; i < `LN_LANES; i++) begin
            lane_in[i].vld  = replay_vld;
            lane_in[i].data = $signed(replay_data[i]);
        end
    end

endmodule

/* source/ln_adder_tree.sv */
`timescale 1ns/1ps
`include "ln_defs.svh"

module ln_adder_tree (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic signed [`LN_LANES-1:0][`LN_DATA_W-1:0] in_data,
    input  logic                                      in_vld,
    output logic signed [`LN_SUM_W-1:0]               sum,
    output logic                                      sum_vld
);

    localparam int L1_N = `LN_LANES / 2;
    localparam int L2_N = `LN_LANES / 4;

    logic [`LN_TREE_LAT-1:0]      vld_pipe;
    logic signed [`LN_DATA_W-1:0] lvl0_q [`LN_LANES];
    logic signed [`LN_DATA_W:0]   lvl1 [L1_N];
    logic signed [`LN_DATA_W+1:0] lvl2 [L2_N];
    logic signed [`LN_DATA_W+1:0] lvl2_q [L2_N];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[`LN_TREE_LAT-2:0], in_vld};
        end
    end

    // input level register
    always_ff @(posedge clk) begin
        if (in_vld) begin
            for (int i = 0; i < `LN_LANES; i++) begin
                lvl0_q[i] <= $signed(in_data[i]);
            end
        end
    end

    // first two adder levels, no register in between
    always_comb begin
        for (int i = 0; i < L1_N; i++) begin
            lvl1[i] = lvl0_q[2*i] + lvl0_q[2*i+1];
        end
        for (int i = 0; i < L2_N; i++) begin
            lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
        end
    end

    // third level register
    always_ff @(posedge clk) begin
        if (vld_pipe[0]) begin
            for (int i = 0; i < L2_N; i++) begin
                lvl2_q[i] <= lvl2[i];
            end
        end
    end

    // final add, sign extended to the accumulator width
    assign sum     = lvl2_q[0] + lvl2_q[1];
    assign sum_vld = vld_pipe[`LN_TREE_LAT-1];

endmodule

/* source/ln_pkg.sv */
`include "ln_defs.svh"

package ln_pkg;

    // one input or output beat, all lanes side by side
    typedef struct packed {
        logic                                      vld;
        logic signed [`LN_LANES-1:0][`LN_DATA_W-1:0] data;
    } ln_beat_t;

    typedef struct packed {
        logic signed [`LN_DATA_W-1:0] gamma;
        logic signed [`LN_DATA_W-1:0] beta;
    } ln_coef_t;

    typedef ln_coef_t [`LN_LANES-1:0] ln_coef_vec_t;

    // shift sits in the low bits of the config word
    typedef struct packed {
        logic [$bits(ln_coef_vec_t)-`LN_SHIFT_W-1:0] pad;
        logic [`LN_SHIFT_W-1:0]                      shift;
    } ln_ctrl_t;

    // same write word, meaning picked by cfg_addr
    typedef union packed {
        ln_coef_vec_t coef;
        ln_ctrl_t     ctrl;
    } ln_cfg_word_u;

    typedef struct packed {
        logic                         vld;
        logic signed [`LN_DATA_W-1:0] data;
    } ln_lane_in_t;

    typedef struct packed {
        logic                         vld;
        logic signed [`LN_DATA_W-1:0] data;
    } ln_lane_out_t;

endpackage

/* source/ln_defs.svh */
`ifndef LN_DEFS_SVH
`define LN_DEFS_SVH

// vector geometry
`define LN_LANES       8
`define LN_DATA_W      8
`define LN_BEATS       4
`define LN_MEAN_SHIFT  5

// internal widths and latency
`define LN_SUM_W       16
`define LN_TREE_LAT    2
`define LN_SHIFT_W     4

// config write addresses
`define LN_ADDR_COEF   0
`define LN_ADDR_CTRL   1

`endif
